// ==== verilog/nes_boot_pkg.sv ====
// shared constants for the cartridge boot path
// boot word and SRAM address widths, word FIFO depth,
// iNES header format, SRAM memory map and mapper_flags field positions
package nes_boot_pkg;

  // host boot words and SRAM addressing
  localparam int boot_word_width = 32;
  localparam int mem_addr_width  = 22;

  // word FIFO between host and loader, depth kept a power of two
  localparam int boot_fifo_depth = 4;
  localparam int fifo_ptr_width  = $clog2(boot_fifo_depth);

  // everything before this byte is dropped
  localparam logic [7:0] skip_marker = 8'h4e;

  // iNES header
  localparam logic [7:0] ines_magic_0 = 8'h4e;
  localparam logic [7:0] ines_magic_1 = 8'h45;
  localparam logic [7:0] ines_magic_2 = 8'h53;
  localparam logic [7:0] ines_magic_3 = 8'h1a;
  localparam int ines_header_bytes  = 16;
  localparam int header_index_width = $clog2(ines_header_bytes);
  localparam logic [header_index_width-1:0] header_last_index =
    header_index_width'(ines_header_bytes - 1);

  // bank sizes and SRAM map, PRG starts at 0
  localparam logic [mem_addr_width-1:0] prg_bank_bytes = mem_addr_width'(16384);
  localparam logic [mem_addr_width-1:0] chr_bank_bytes = mem_addr_width'(8192);
  localparam logic [mem_addr_width-1:0] chr_base_addr  = mem_addr_width'(32'h0020_0000);

  // mapper_flags layout, bits 15..10 stay zero
  localparam int flags_mapper_lsb = 0;
  localparam int flags_mirror_bit = 8;
  localparam int flags_battery_bit = 9;
  localparam int flags_prg_lsb = 16;
  localparam int flags_chr_lsb = 24;

endpackage

// ==== verilog/boot_word_buffer.sv ====
`timescale 1ns/1ns
// host boot word buffer
// request/acknowledge handshake with rom_size gate, small word FIFO,
// byte unpacker that drops everything before the first 'N'
module boot_word_buffer (
  input  logic                                     clk,
  input  logic                                     host_reset_loader,
  input  logic [nes_boot_pkg::boot_word_width-1:0] host_bootdata,
  input  logic                                     host_bootdata_req,
  input  logic [31:0]                              rom_size,
  input  logic                                     byte_take,
  output logic                                     host_bootdata_ack,
  output logic                                     byte_valid,
  output logic [7:0]                               byte_data
);

  typedef enum logic {ack_idle, ack_send} ack_state_t;

  ack_state_t ack_state;
  logic [31:0] bytes_loaded;

  logic [nes_boot_pkg::boot_word_width-1:0] fifo_mem [nes_boot_pkg::boot_fifo_depth];
  logic [nes_boot_pkg::fifo_ptr_width-1:0] wr_ptr;
  logic [nes_boot_pkg::fifo_ptr_width-1:0] rd_ptr;
  logic [nes_boot_pkg::fifo_ptr_width:0] fifo_count;
  logic [nes_boot_pkg::boot_word_width-1:0] head_word;
  logic [1:0] byte_sel;
  logic skip;

  logic fifo_full;
  logic fifo_empty;
  logic accept;
  logic store;
  logic advance;
  logic pop;

  // count reaches the depth only with its top bit set
  assign fifo_full  = fifo_count[nes_boot_pkg::fifo_ptr_width];
  assign fifo_empty = (fifo_count == '0);

  // words past rom_size are acknowledged but not stored
  assign accept = (ack_state == ack_idle) && host_bootdata_req && !fifo_full;
  assign store  = accept && (bytes_loaded < rom_size);

  assign host_bootdata_ack = (ack_state == ack_send);

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      ack_state    <= ack_idle;
      bytes_loaded <= '0;
    end else begin
      case (ack_state)
        ack_idle: if (accept) ack_state <= ack_send;
        default:  ack_state <= ack_idle;
      endcase
      // four bytes per boot word
      if (store) bytes_loaded <= bytes_loaded + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (store) fifo_mem[wr_ptr] <= host_bootdata;
  end

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (store) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({store, pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  // head word unpacked least significant byte first
  assign head_word = fifo_mem[rd_ptr];
  assign byte_data = head_word[{byte_sel, 3'b000} +: 8];

  // in skip mode only the marker itself is offered
  assign byte_valid = !fifo_empty && (!skip || byte_data == nes_boot_pkg::skip_marker);
  assign advance = (byte_valid && byte_take) ||
                   (!fifo_empty && skip && byte_data != nes_boot_pkg::skip_marker);
  assign pop = advance && (byte_sel == 2'd3);

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      byte_sel <= '0;
      skip     <= 1'b1;
    end else begin
      if (advance) byte_sel <= byte_sel + 1'b1;
      if (byte_valid && byte_take) skip <= 1'b0;
    end
  end

endmodule

// ==== verilog/sram_write_controller.sv ====
`timescale 1ns/1ns
// write-only SRAM controller
// registered address and data, one-cycle active-low write strobe,
// busy hold-off between writes
module sram_write_controller (
  input  logic                                    clk,
  input  logic                                    host_reset_loader,
  input  logic                                    mem_write,
  input  logic [nes_boot_pkg::mem_addr_width-1:0] mem_addr,
  input  logic [7:0]                              mem_data,
  output logic                                    ram_busy,
  output logic                                    ram_we_n,
  output logic [nes_boot_pkg::mem_addr_width-1:0] ram_a,
  output logic [7:0]                              ram_d
);

  logic [1:0] busy_count;
  logic write_go;

  assign write_go = mem_write && !ram_busy;

  // busy for the strobe cycle and one hold cycle after it
  assign ram_busy = (busy_count != 2'd0);

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      busy_count <= '0;
      ram_we_n   <= 1'b1;
    end else begin
      ram_we_n <= !write_go;
      if (write_go) begin
        busy_count <= 2'd2;
      end else if (ram_busy) begin
        busy_count <= busy_count - 1'b1;
      end
    end
  end

  // address and data stay put through the strobe and the hold cycle
  always_ff @(posedge clk) begin
    if (write_go) begin
      ram_a <= mem_addr;
      ram_d <= mem_data;
    end
  end

endmodule

// ==== verilog/ines_game_loader.sv ====
`timescale 1ns/1ns
// iNES game loader
// header parse with magic and bank count checks, mapper_flags,
// PRG and CHR copy into SRAM, done and fail status
module ines_game_loader (
  input  logic                                    clk,
  input  logic                                    host_reset_loader,
  input  logic                                    byte_valid,
  input  logic [7:0]                              byte_data,
  input  logic                                    ram_busy,
  output logic                                    byte_take,
  output logic                                    mem_write,
  output logic [nes_boot_pkg::mem_addr_width-1:0] mem_addr,
  output logic [7:0]                              mem_data,
  output logic [31:0]                             mapper_flags,
  output logic                                    loader_done,
  output logic                                    loader_fail
);

  typedef enum logic [1:0] {st_header, st_data, st_done, st_fail} state_t;

  state_t state;
  logic [nes_boot_pkg::header_index_width-1:0] hdr_count;
  logic magic_bad;
  logic [7:0] hdr_prg;
  logic [7:0] hdr_chr;
  logic [7:0] hdr_flags6;
  logic [7:0] hdr_flags7;
  logic [nes_boot_pkg::mem_addr_width-1:0] prg_left;
  logic [nes_boot_pkg::mem_addr_width-1:0] chr_left;
  logic [nes_boot_pkg::mem_addr_width-1:0] prg_next;
  logic [nes_boot_pkg::mem_addr_width-1:0] chr_next;
  logic [7:0] magic_expected;
  logic magic_mismatch;
  logic hdr_move;
  logic [31:0] flags_next;

  assign hdr_move = (state == st_header) && byte_valid;

  // data bytes are only taken when the write can go out in the same cycle
  assign byte_take = (state == st_header) || (state == st_data && !ram_busy);
  assign mem_write = (state == st_data) && byte_valid && !ram_busy;
  assign mem_data  = byte_data;

  assign loader_done = (state == st_done);
  assign loader_fail = (state == st_fail);

  always_comb begin
    case (hdr_count[1:0])
      2'd0:    magic_expected = nes_boot_pkg::ines_magic_0;
      2'd1:    magic_expected = nes_boot_pkg::ines_magic_1;
      2'd2:    magic_expected = nes_boot_pkg::ines_magic_2;
      default: magic_expected = nes_boot_pkg::ines_magic_3;
    endcase
  end
  assign magic_mismatch = (byte_data != magic_expected);

  always_comb begin
    flags_next = '0;
    flags_next[nes_boot_pkg::flags_mapper_lsb +: 8] = {hdr_flags7[7:4], hdr_flags6[7:4]};
    flags_next[nes_boot_pkg::flags_mirror_bit]  = hdr_flags6[0];
    flags_next[nes_boot_pkg::flags_battery_bit] = hdr_flags6[1];
    flags_next[nes_boot_pkg::flags_prg_lsb +: 8] = hdr_prg;
    flags_next[nes_boot_pkg::flags_chr_lsb +: 8] = hdr_chr;
  end

  assign prg_next = prg_left - 1'b1;
  assign chr_next = chr_left - 1'b1;

  // raw header bytes 4 to 7
  always_ff @(posedge clk) begin
    if (hdr_move) begin
      case (hdr_count)
        4'd4:    hdr_prg <= byte_data;
        4'd5:    hdr_chr <= byte_data;
        4'd6:    hdr_flags6 <= byte_data;
        4'd7:    hdr_flags7 <= byte_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      state        <= st_header;
      hdr_count    <= '0;
      magic_bad    <= 1'b0;
      mapper_flags <= '0;
      mem_addr     <= '0;
      prg_left     <= '0;
      chr_left     <= '0;
    end else if (hdr_move) begin
      hdr_count <= hdr_count + 1'b1;
      if (hdr_count[3:2] == 2'd0 && magic_mismatch) magic_bad <= 1'b1;
      if (hdr_count == 4'd3 && (magic_bad || magic_mismatch)) begin
        state <= st_fail;
      end else if (hdr_count == 4'd4 && byte_data == 8'd0) begin
        state <= st_fail;
      end else if (hdr_count == nes_boot_pkg::header_last_index) begin
        // header complete, publish flags and byte totals
        state        <= st_data;
        mapper_flags <= flags_next;
        prg_left     <= hdr_prg * nes_boot_pkg::prg_bank_bytes;
        chr_left     <= hdr_chr * nes_boot_pkg::chr_bank_bytes;
      end
    end else if (mem_write) begin
      if (prg_left != '0) begin
        prg_left <= prg_next;
        if (prg_next == '0) begin
          // last PRG byte, CHR region follows
          mem_addr <= nes_boot_pkg::chr_base_addr;
          if (chr_left == '0) state <= st_done;
        end else begin
          mem_addr <= mem_addr + 1'b1;
        end
      end else begin
        chr_left <= chr_next;
        mem_addr <= mem_addr + 1'b1;
        if (chr_next == '0) state <= st_done;
      end
    end
  end

endmodule

// ==== verilog/rom_boot_loader.sv ====
`timescale 1ns/1ns
// cartridge boot path top level
// word buffer, iNES loader and SRAM write controller
module rom_boot_loader (
  input  logic                                     clk,
  input  logic                                     host_reset_loader,
  input  logic [nes_boot_pkg::boot_word_width-1:0] host_bootdata,
  input  logic                                     host_bootdata_req,
  input  logic [31:0]                              rom_size,
  output logic                                     host_bootdata_ack,
  output logic [31:0]                              mapper_flags,
  output logic                                     loader_done,
  output logic                                     loader_fail,
  output logic                                     ram_we_n,
  output logic [nes_boot_pkg::mem_addr_width-1:0]  ram_a,
  output logic [7:0]                               ram_d
);

  // byte pull between buffer and loader
  logic       byte_valid;
  logic [7:0] byte_data;
  logic       byte_take;

  // loader write port
  logic                                    mem_write;
  logic [nes_boot_pkg::mem_addr_width-1:0] mem_addr;
  logic [7:0]                              mem_data;
  logic                                    ram_busy;

  boot_word_buffer u_buffer (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .host_bootdata     (host_bootdata),
    .host_bootdata_req (host_bootdata_req),
    .rom_size          (rom_size),
    .byte_take         (byte_take),
    .host_bootdata_ack (host_bootdata_ack),
    .byte_valid        (byte_valid),
    .byte_data         (byte_data)
  );

  ines_game_loader u_loader (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .byte_valid        (byte_valid),
    .byte_data         (byte_data),
    .ram_busy          (ram_busy),
    .byte_take         (byte_take),
    .mem_write         (mem_write),
    .mem_addr          (mem_addr),
    .mem_data          (mem_data),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail)
  );

  sram_write_controller u_sram (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .mem_write         (mem_write),
    .mem_addr          (mem_addr),
    .mem_data          (mem_data),
    .ram_busy          (ram_busy),
    .ram_we_n          (ram_we_n),
    .ram_a             (ram_a),
    .ram_d             (ram_d)
  );

endmodule

// ==== tests/rom_boot_checker.sv ====
`timescale 1ns/1ns
// boot path checker
// compares every SRAM write strobe with the expected write list,
// then done/fail, mapper_flags and write count, and counts errors
module rom_boot_checker (
  input  logic                                    clk,
  input  logic                                    host_reset_loader,
  input  logic                                    ram_we_n,
  input  logic [nes_boot_pkg::mem_addr_width-1:0] ram_a,
  input  logic [7:0]                              ram_d,
  input  logic [31:0]                             mapper_flags,
  input  logic                                    loader_done,
  input  logic                                    loader_fail,
  input  logic [nes_boot_pkg::mem_addr_width+7:0] exp_write
    [int'(nes_boot_pkg::prg_bank_bytes + nes_boot_pkg::chr_bank_bytes)],
  input  int                                      exp_count,
  input  logic [31:0]                             exp_flags,
  input  logic                                    exp_fail,
  output int                                      error_count,
  output logic                                    status_seen
);

  int   errors = 0;
  int   write_idx = 0;
  logic status_flag = 1'b0;
  logic after_reset = 1'b0;
  logic held_done = 1'b0;
  logic held_fail = 1'b0;

  assign error_count = errors;
  assign status_seen = status_flag;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
             $time, name, expected, actual);
    errors++;
  endtask

  // DUT outputs move on the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (host_reset_loader) begin
      write_idx   = 0;
      status_flag = 1'b0;
      after_reset = 1'b1;
    end else begin
      // first cycle out of reset
      if (after_reset) begin
        if (mapper_flags != 32'h0) report_mismatch("mapper_flags", 32'h0, mapper_flags);
        if (loader_done) report_mismatch("loader_done", 32'd0, 32'd1);
        if (loader_fail) report_mismatch("loader_fail", 32'd0, 32'd1);
        after_reset = 1'b0;
      end
      if (!ram_we_n) begin
        if (write_idx >= exp_count) begin
          $display("unexpected SRAM write to 0x%0h at %0t ns, only %0d writes expected",
                   ram_a, $time, exp_count);
          errors++;
        end else begin
          if (ram_a != exp_write[write_idx][nes_boot_pkg::mem_addr_width+7:8]) begin
            report_mismatch("ram_a",
                            32'(exp_write[write_idx][nes_boot_pkg::mem_addr_width+7:8]),
                            32'(ram_a));
          end
          if (ram_d != exp_write[write_idx][7:0]) begin
            report_mismatch("ram_d", 32'(exp_write[write_idx][7:0]), 32'(ram_d));
          end
        end
        write_idx++;
      end
      // done and fail hold until the next reset
      if (status_flag && (loader_done != held_done || loader_fail != held_fail)) begin
        $display("loader status changed after done or fail was reached, at %0t ns", $time);
        errors++;
        held_done = loader_done;
        held_fail = loader_fail;
      end
      // the last strobe and loader_done share a cycle, so count it first
      if ((loader_done || loader_fail) && !status_flag) begin
        status_flag = 1'b1;
        held_done   = loader_done;
        held_fail   = loader_fail;
        if (loader_fail != exp_fail) begin
          report_mismatch("loader_fail", 32'(exp_fail), 32'(loader_fail));
        end
        if (loader_done == exp_fail) begin
          report_mismatch("loader_done", 32'(!exp_fail), 32'(loader_done));
        end
        if (mapper_flags != exp_flags) report_mismatch("mapper_flags", exp_flags, mapper_flags);
        if (write_idx != exp_count) report_mismatch("write count", exp_count, write_idx);
      end
    end
  end

endmodule

// ==== tests/rom_boot_loader_tb.sv ====
`timescale 1ns/1ns
// testbench for the cartridge boot path
// clock and reset, host model streaming iNES images, reference model,
// watchdog and closing report
module rom_boot_loader_tb;

  typedef logic [nes_boot_pkg::mem_addr_width-1:0] addr_t;

  localparam int max_writes = int'(nes_boot_pkg::prg_bank_bytes + nes_boot_pkg::chr_bank_bytes);
  localparam int max_image = max_writes + 32;
  localparam int ack_limit = 64;
  localparam int status_limit = 256;
  // six images at four cycles per byte, plus a margin per test
  localparam int watchdog_cycles =
    4 * (3 * max_image + 2 * (int'(nes_boot_pkg::prg_bank_bytes) + 32)) + 6 * 1000;

  logic        clk;
  logic        host_reset_loader;
  logic [31:0] host_bootdata;
  logic        host_bootdata_req;
  logic [31:0] rom_size;
  logic        host_bootdata_ack;
  logic [31:0] mapper_flags;
  logic        loader_done;
  logic        loader_fail;
  logic        ram_we_n;
  addr_t       ram_a;
  logic [7:0]  ram_d;

  logic [7:0] image [max_image];
  int         image_len;
  logic [nes_boot_pkg::mem_addr_width+7:0] exp_write [max_writes];
  int         exp_count;
  logic [31:0] exp_flags;
  logic       exp_fail;
  int         check_errors;
  logic       status_seen;
  int         host_errors;
  int         seed;

  rom_boot_loader u_dut (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .host_bootdata     (host_bootdata),
    .host_bootdata_req (host_bootdata_req),
    .rom_size          (rom_size),
    .host_bootdata_ack (host_bootdata_ack),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail),
    .ram_we_n          (ram_we_n),
    .ram_a             (ram_a),
    .ram_d             (ram_d)
  );

  rom_boot_checker u_check (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .ram_we_n          (ram_we_n),
    .ram_a             (ram_a),
    .ram_d             (ram_d),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail),
    .exp_write         (exp_write),
    .exp_count         (exp_count),
    .exp_flags         (exp_flags),
    .exp_fail          (exp_fail),
    .error_count       (check_errors),
    .status_seen       (status_seen)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("test failed");
    $finish;
  end

  // garbage, 16-byte header, optional bank data, random padding to whole words
  task automatic build_image(input int garbage, input logic [7:0] prg, input logic [7:0] chr,
                             input logic [7:0] flags6, input logic [7:0] flags7,
                             input int bad_pos, input bit with_data);
    int n;
    int data_len;
    logic [7:0] b;
    image_len = 0;
    for (n = 0; n < garbage; n++) begin
      b = 8'($random(seed));
      // no marker allowed in the garbage
      if (b == nes_boot_pkg::skip_marker) b = 8'h00;
      image[n] = b;
    end
    image_len = garbage;
    image[image_len]     = nes_boot_pkg::ines_magic_0;
    image[image_len + 1] = nes_boot_pkg::ines_magic_1;
    image[image_len + 2] = nes_boot_pkg::ines_magic_2;
    image[image_len + 3] = nes_boot_pkg::ines_magic_3;
    image[image_len + 4] = prg;
    image[image_len + 5] = chr;
    image[image_len + 6] = flags6;
    image[image_len + 7] = flags7;
    for (n = 8; n < 16; n++) begin
      image[image_len + n] = 8'h00;
    end
    if (bad_pos >= 0) image[image_len + bad_pos] = 8'h00;
    image_len += 16;
    data_len = 0;
    if (with_data) begin
      data_len = int'(prg) * int'(nes_boot_pkg::prg_bank_bytes) +
                 int'(chr) * int'(nes_boot_pkg::chr_bank_bytes);
    end
    for (n = 0; n < data_len; n++) begin
      image[image_len + n] = 8'($random(seed));
    end
    image_len += data_len;
    while (image_len % 4 != 0) begin
      image[image_len] = 8'($random(seed));
      image_len++;
    end
    rom_size <= image_len;
  endtask

  // expected flags, outcome and write list straight from the iNES rules
  function automatic int expected_result();
    int start;
    int prg_total;
    int chr_total;
    int n;
    logic [7:0] hdr [16];
    start = 0;
    while (start < image_len && image[start] != nes_boot_pkg::skip_marker) begin
      start++;
    end
    for (n = 0; n < 16; n++) begin
      hdr[n] = image[start + n];
    end
    exp_flags = 32'h0;
    exp_fail = (hdr[0] != nes_boot_pkg::ines_magic_0) || (hdr[1] != nes_boot_pkg::ines_magic_1) ||
               (hdr[2] != nes_boot_pkg::ines_magic_2) || (hdr[3] != nes_boot_pkg::ines_magic_3) ||
               (hdr[4] == 8'd0);
    if (exp_fail) begin
      return 0;
    end
    exp_flags = {hdr[5], hdr[4], 6'b000000, hdr[6][1], hdr[6][0], hdr[7][7:4], hdr[6][7:4]};
    prg_total = int'(hdr[4]) * int'(nes_boot_pkg::prg_bank_bytes);
    chr_total = int'(hdr[5]) * int'(nes_boot_pkg::chr_bank_bytes);
    for (n = 0; n < prg_total; n++) begin
      exp_write[n] = {addr_t'(n), image[start + 16 + n]};
    end
    // CHR lands at its own base, in image order
    for (n = 0; n < chr_total; n++) begin
      exp_write[prg_total + n] = {nes_boot_pkg::chr_base_addr + addr_t'(n),
                                  image[start + 16 + prg_total + n]};
    end
    return prg_total + chr_total;
  endfunction

  // image words first, junk past rom_size after them
  task automatic send_words(input int junk_words, input bit gaps);
    int n;
    int waited;
    int gap;
    for (n = 0; n < image_len / 4 + junk_words; n++) begin
      if (n < image_len / 4) begin
        host_bootdata <= {image[4*n+3], image[4*n+2], image[4*n+1], image[4*n]};
      end else begin
        host_bootdata <= $random(seed);
      end
      host_bootdata_req <= 1'b1;
      waited = 0;
      @(posedge clk);
      while (!host_bootdata_ack && waited < ack_limit) begin
        @(posedge clk);
        waited++;
      end
      host_bootdata_req <= 1'b0;
      if (!host_bootdata_ack) begin
        $display("host: word %0d was never acknowledged", n);
        host_errors++;
        return;
      end
      @(posedge clk);
      if (gaps) begin
        gap = $random(seed) & 7;
        repeat (gap) @(posedge clk);
      end
    end
  endtask

  task automatic run_test(input int junk_words, input bit gaps);
    int waited;
    exp_count = expected_result();
    host_reset_loader <= 1'b1;
    repeat (4) @(posedge clk);
    host_reset_loader <= 1'b0;
    send_words(junk_words, gaps);
    waited = 0;
    while (!status_seen && waited < status_limit) begin
      @(posedge clk);
      waited++;
    end
    if (!status_seen) begin
      $display("loader reached neither done nor fail after the last word");
      host_errors++;
    end
    // room for a stray strobe to show up
    repeat (16) @(posedge clk);
  endtask

  initial begin
    seed = 32'h9102_79ca;
    host_errors = 0;
    host_reset_loader = 1'b1;
    host_bootdata_req = 1'b0;
    host_bootdata = 32'h0;
    rom_size = 32'h0;
    exp_count = 0;
    exp_flags = 32'h0;
    exp_fail = 1'b0;
    image_len = 0;
    @(posedge clk);
    // mapper 4, vertical mirroring, battery, garbage in front
    build_image(5, 8'd1, 8'd1, 8'h43, 8'h00, -1, 1'b1);
    run_test(3, 1'b0);
    // bad magic at header byte 2
    build_image(0, 8'd1, 8'd1, 8'h00, 8'h00, 2, 1'b0);
    run_test(3, 1'b0);
    // zero PRG banks
    build_image(0, 8'd0, 8'd1, 8'h00, 8'h00, -1, 1'b0);
    run_test(3, 1'b0);
    // rom_size exact, long junk tail
    build_image(0, 8'd1, 8'd0, 8'h10, 8'h20, -1, 1'b1);
    run_test(16, 1'b0);
    // random host gaps, PRG only
    build_image(3, 8'd1, 8'd0, 8'h01, 8'h00, -1, 1'b1);
    run_test(3, 1'b1);
    // reload after reset, old flags must be gone
    build_image(2, 8'd1, 8'd1, 8'h22, 8'h10, -1, 1'b1);
    run_test(3, 1'b0);
    $display("errors: %0d from the checker, %0d from the host model", check_errors, host_errors);
    if (check_errors == 0 && host_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== rom_boot_loader.f ====
verilog/nes_boot_pkg.sv
verilog/boot_word_buffer.sv
verilog/sram_write_controller.sv
verilog/ines_game_loader.sv
verilog/rom_boot_loader.sv
tests/rom_boot_checker.sv
tests/rom_boot_loader_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = rom_boot_loader_tb
FILELIST  = rom_boot_loader.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, a missing pass line fails the target
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
